// ==== sources.f ====
+incdir+include
source/videoPkg.sv
source/framePkg.sv
source/scanTiming.sv
source/pixelPipe.sv
source/hostDraw.sv
source/memArbiter.sv
source/frameMemory.sv
source/vgaFrameTop.sv
bench/vgaFrameBench.sv

// ==== run.sh ====
#!/bin/sh
# Builds the bench with Verilator and runs it; exit status follows the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f sources.f --top-module vgaFrameBench \
	--Mdir build -o vgaFrameSim
./build/vgaFrameSim | tee sim.log

if grep -q "^Testbench passed$" sim.log; then
	echo "Simulation PASS"
	exit 0
fi
echo "Simulation FAIL"
exit 1

// ==== bench/vgaFrameBench.sv ====
// Runs about 1.2 million clocks; pixels are only checked after a fill, since the memory starts undefined
`timescale 1ns/1ps
`default_nettype none

`include "video_cfg.svh"

module vgaFrameBench;

	localparam int FrameCycles = `H_TOTAL * `V_TOTAL;
	localparam int VSyncCycles = `V_SYNC * `H_TOTAL;
	// Pixel 0 comes sync plus back porch after the previous line's HSync fall
	localparam int PixelOffset = `H_SYNC + `H_BACK;
	// HSync falls from the VSync fall to the first active line
	localparam int FirstLine = `V_SYNC + `V_BACK;
	localparam int PlotCount = 40;
	// First VSync near 0.4 million, then two checked frames of 0.42 million each
	localparam int CycleLimit = 1_500_000;

	logic Clock;
	logic Reset;
	logic drawStrobe;
	framePkg::drawCommand drawCommand;
	logic drawBusy;
	logic Red_o;
	logic Green_o;
	logic Blue_o;
	logic HSync_o;
	logic VSync_o;

	logic [2:0] frameModel [0:63][0:127];
	int errorCount;
	int cycleCount;
	int seed;
	// Monitor state
	logic prevH;
	logic prevV;
	logic hSeen;
	logic vSeen;
	int hPos;
	int vPos;
	int hLow;
	int vLow;
	int lineNum;
	logic checkArmed;
	logic checking;
	logic frameDone;

	vgaFrameTop dut0 (
		.Clock(Clock),
		.Reset(Reset),
		.DrawStrobe_i(drawStrobe),
		.DrawCommand_i(drawCommand),
		.DrawBusy_o(drawBusy),
		.Red_o(Red_o),
		.Green_o(Green_o),
		.Blue_o(Blue_o),
		.HSync_o(HSync_o),
		.VSync_o(VSync_o)
	);

	initial begin
		Clock = 1'b0;
		forever #50 Clock = ~Clock;
	end

	initial begin
		cycleCount = 0;
		while (cycleCount < CycleLimit) begin
			@(posedge Clock);
			cycleCount++;
		end
		$display("Timeout: no result after %0d clock cycles", CycleLimit);
		$display("Testbench failed");
		$finish;
	end

	task automatic reportError(input string message);
		errorCount++;
		if (errorCount <= 30)
			$display("** Error at %0t ns: %s", $time, message);
	endtask

	task automatic applyToModel(input framePkg::drawCommand cmd);
		if (cmd.op == framePkg::OpFill) begin
			for (int r = 0; r < `GRID_ROWS; r++)
				for (int c = 0; c < `GRID_COLS; c++)
					frameModel[6'(r)][7'(c)] = cmd.colour;
		end else begin
			frameModel[cmd.row][cmd.column] = cmd.colour;
		end
	endtask

	// Strobe for one cycle; accepted when busy was low while the strobe was up
	task automatic sendCommand(input framePkg::drawOp op, input int column, input int row,
			input logic [2:0] colour, output logic accepted);
		framePkg::drawCommand cmd;
		cmd.op = op;
		cmd.column = 7'(column);
		cmd.row = 6'(row);
		cmd.colour = colour;
		@(posedge Clock);
		drawStrobe <= 1'b1;
		drawCommand <= cmd;
		@(negedge Clock);
		accepted = !drawBusy;
		if (accepted)
			applyToModel(cmd);
		@(posedge Clock);
		drawStrobe <= 1'b0;
		@(negedge Clock);
		if (accepted && !drawBusy)
			reportError("DrawBusy_o did not rise after an accepted command");
	endtask

	task automatic waitIdle;
		@(negedge Clock);
		while (drawBusy)
			@(negedge Clock);
	endtask

	// The monitor checks the frame that starts at the next VSync fall
	task automatic checkNextFrame;
		@(posedge Clock);
		frameDone = 1'b0;
		checkArmed = 1'b1;
		while (!frameDone)
			@(posedge Clock);
	endtask

	task automatic checkResetState;
		if (HSync_o !== 1'b1 || VSync_o !== 1'b1)
			reportError("syncs not high after reset");
		if ({Blue_o, Green_o, Red_o} !== 3'b000)
			reportError("colours not 0 after reset");
		if (drawBusy !== 1'b0)
			reportError("DrawBusy_o not low after reset");
	endtask

	// Sync timing and pixel checks, sampled on the falling edge
	always @(negedge Clock) begin
		logic [2:0] want;
		logic [2:0] seen;
		int x;
		int y;
		if (!Reset) begin
			prevH = 1'b1;
			prevV = 1'b1;
			hSeen = 1'b0;
			vSeen = 1'b0;
			hPos = 0;
			vPos = 0;
			hLow = 0;
			vLow = 0;
			lineNum = 0;
		end else begin
			hPos++;
			vPos++;
			if (prevV && !VSync_o) begin
				if (vSeen && vPos != FrameCycles)
					reportError($sformatf("VSync period %0d, expected %0d", vPos, FrameCycles));
				vSeen = 1'b1;
				vPos = 0;
				vLow = 0;
				lineNum = 0;
				if (checkArmed) begin
					checking = 1'b1;
					checkArmed = 1'b0;
				end
			end
			if (!prevV && VSync_o && vLow != VSyncCycles)
				reportError($sformatf("VSync low %0d, expected %0d", vLow, VSyncCycles));
			if (!VSync_o)
				vLow++;
			if (prevH && !HSync_o) begin
				if (hSeen && hPos != `H_TOTAL)
					reportError($sformatf("HSync period %0d, expected %0d", hPos, `H_TOTAL));
				hSeen = 1'b1;
				hPos = 0;
				hLow = 0;
				lineNum++;
			end
			if (!prevH && HSync_o && hLow != `H_SYNC)
				reportError($sformatf("HSync low %0d, expected %0d", hLow, `H_SYNC));
			if (!HSync_o)
				hLow++;
			if (checking) begin
				if (lineNum >= FirstLine + `V_ACTIVE) begin
					checking = 1'b0;
					frameDone = 1'b1;
				end else begin
					y = lineNum - FirstLine;
					x = hPos - PixelOffset;
					want = 3'b000;
					if (y >= 0 && y < `V_ACTIVE && x >= 0 && x < `H_ACTIVE)
						want = frameModel[6'(y >> `CELL_SHIFT)][7'(x >> `CELL_SHIFT)];
					seen = {Blue_o, Green_o, Red_o};
					if (seen !== want)
						reportError($sformatf("pixel %0d line %0d is %0d, expected %0d",
							x, y, seen, want));
				end
			end
			prevH = HSync_o;
			prevV = VSync_o;
		end
	end

	initial begin
		logic accepted;
		logic [2:0] colour;
		int column;
		int row;
		seed = 32'h7c52;
		Reset = 1'b0;
		drawStrobe = 1'b0;
		drawCommand = '0;
		errorCount = 0;
		checkArmed = 1'b0;
		checking = 1'b0;
		frameDone = 1'b0;
		for (int r = 0; r < 64; r++)
			for (int c = 0; c < 128; c++)
				frameModel[6'(r)][7'(c)] = 3'b000;
		repeat (2) @(posedge Clock);
		Reset <= 1'b1;
		@(negedge Clock);
		checkResetState();

		// Fill, then strobes while busy that must be dropped
		colour = 3'(1 + $unsigned($random(seed)) % 7);
		sendCommand(framePkg::OpFill, 0, 0, colour, accepted);
		if (!accepted)
			reportError("fill command found DrawBusy_o high");
		for (int i = 0; i < 4; i++) begin
			sendCommand(framePkg::OpPlot, i, i, ~colour, accepted);
			if (accepted)
				reportError("DrawBusy_o low while a fill was running");
		end
		waitIdle();
		checkNextFrame();

		// Random plots, each run to completion
		for (int i = 0; i < PlotCount; i++) begin
			column = $unsigned($random(seed)) % `GRID_COLS;
			row = $unsigned($random(seed)) % `GRID_ROWS;
			colour = 3'($unsigned($random(seed)) % 8);
			sendCommand(framePkg::OpPlot, column, row, colour, accepted);
			if (!accepted)
				reportError("plot command found DrawBusy_o high");
			waitIdle();
		end
		checkNextFrame();

		$display("Finished with %0d errors", errorCount);
		if (errorCount == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== source/vgaFrameTop.sv ====
// Expects a 25.175 MHz clock; framebuffer is undefined until the host has drawn to it
`timescale 1ns/1ps
`default_nettype none

module vgaFrameTop (
	input  wire Clock,
	input  wire Reset,
	input  wire DrawStrobe_i,
	input  framePkg::drawCommand DrawCommand_i,
	output logic DrawBusy_o,
	output logic Red_o,
	output logic Green_o,
	output logic Blue_o,
	output logic HSync_o,
	output logic VSync_o
);

	videoPkg::scanInfo scan;
	framePkg::memRequest fetchRequest;
	framePkg::memRequest drawRequest;
	framePkg::memRequest memPort;
	framePkg::cellColour readData;
	logic drawGrant;

	scanTiming scanTiming0 (
		.Clock(Clock),
		.Reset(Reset),
		.Scan_o(scan)
	);

	pixelPipe pixelPipe0 (
		.Clock(Clock),
		.Reset(Reset),
		.Scan_i(scan),
		.FetchRequest_o(fetchRequest),
		.ReadData_i(readData),
		.Red_o(Red_o),
		.Green_o(Green_o),
		.Blue_o(Blue_o),
		.HSync_o(HSync_o),
		.VSync_o(VSync_o)
	);

	hostDraw hostDraw0 (
		.Clock(Clock),
		.Reset(Reset),
		.DrawStrobe_i(DrawStrobe_i),
		.DrawCommand_i(DrawCommand_i),
		.DrawRequest_o(drawRequest),
		.DrawGrant_i(drawGrant),
		.DrawBusy_o(DrawBusy_o)
	);

	memArbiter memArbiter0 (
		.FetchRequest_i(fetchRequest),
		.DrawRequest_i(drawRequest),
		.MemPort_o(memPort),
		.DrawGrant_o(drawGrant)
	);

	frameMemory frameMemory0 (
		.Clock(Clock),
		.MemPort_i(memPort),
		.ReadData_o(readData)
	);

endmodule

`default_nettype wire

// ==== source/frameMemory.sv ====
// Contents are undefined after power-up; read data changes only on a valid read
`timescale 1ns/1ps
`default_nettype none

`include "video_cfg.svh"

module frameMemory (
	input  wire Clock,
	input  framePkg::memRequest MemPort_i,
	output framePkg::cellColour ReadData_o
);

	localparam int Depth = 1 << `ADDR_BITS;

	framePkg::cellColour cells [0:Depth-1];

	// Single port, write or registered read
	always_ff @(posedge Clock) begin
		if (MemPort_i.valid) begin
			if (MemPort_i.write)
				cells[MemPort_i.address] <= MemPort_i.data;
			else
				ReadData_o <= cells[MemPort_i.address];
		end
	end

endmodule

`default_nettype wire

// ==== source/memArbiter.sv ====
// Fixed priority; relies on fetches being at most one in 8 cycles so draws are never starved
`timescale 1ns/1ps
`default_nettype none

module memArbiter (
	input  framePkg::memRequest FetchRequest_i,
	input  framePkg::memRequest DrawRequest_i,
	output framePkg::memRequest MemPort_o,
	output logic DrawGrant_o
);

	// Display fetch always takes the port
	always_comb begin
		if (FetchRequest_i.valid) begin
			MemPort_o = FetchRequest_i;
			DrawGrant_o = 1'b0;
		end else begin
			MemPort_o = DrawRequest_i;
			// Grant ends the draw write in this cycle
			DrawGrant_o = DrawRequest_i.valid;
		end
	end

endmodule

`default_nettype wire

// ==== source/hostDraw.sv ====
// One command at a time; strobes while busy are dropped and a fill covers only the visible grid
`timescale 1ns/1ps
`default_nettype none

`include "video_cfg.svh"

module hostDraw (
	input  wire Clock,
	input  wire Reset,
	input  wire DrawStrobe_i,
	input  framePkg::drawCommand DrawCommand_i,
	output framePkg::memRequest DrawRequest_o,
	input  wire DrawGrant_i,
	output logic DrawBusy_o
);

	typedef enum logic [1:0] {
		DrawIdle,
		DrawPlot,
		DrawFill
	} drawState;

	localparam logic [6:0] LastCol = 7'(`GRID_COLS - 1);
	localparam logic [5:0] LastRow = 6'(`GRID_ROWS - 1);

	drawState state;
	logic [6:0] cursorCol;
	logic [5:0] cursorRow;
	framePkg::cellColour colour;

	// Control
	always_ff @(posedge Clock, negedge Reset) begin
		if (!Reset) begin
			state <= DrawIdle;
		end else begin
			case (state)
				DrawIdle:
					if (DrawStrobe_i)
						state <= (DrawCommand_i.op == framePkg::OpFill) ? DrawFill : DrawPlot;
				DrawPlot:
					if (DrawGrant_i)
						state <= DrawIdle;
				DrawFill:
					if (DrawGrant_i && cursorCol == LastCol && cursorRow == LastRow)
						state <= DrawIdle;
				default:
					state <= DrawIdle;
			endcase
		end
	end

	// Cursor and colour, loaded on capture
	always_ff @(posedge Clock) begin
		if (state == DrawIdle && DrawStrobe_i) begin
			colour <= DrawCommand_i.colour;
			if (DrawCommand_i.op == framePkg::OpFill) begin
				cursorCol <= '0;
				cursorRow <= '0;
			end else begin
				cursorCol <= DrawCommand_i.column;
				cursorRow <= DrawCommand_i.row;
			end
		end else if (state == DrawFill && DrawGrant_i) begin
			// Row-major walk over the visible cells
			if (cursorCol == LastCol) begin
				cursorCol <= '0;
				cursorRow <= cursorRow + 6'd1;
			end else begin
				cursorCol <= cursorCol + 7'd1;
			end
		end
	end

	always_comb begin
		DrawRequest_o.valid = (state != DrawIdle);
		DrawRequest_o.write = 1'b1;
		DrawRequest_o.address.row = cursorRow;
		DrawRequest_o.address.column = cursorCol;
		DrawRequest_o.data = colour;
	end

	assign DrawBusy_o = (state != DrawIdle);

endmodule

`default_nettype wire

// ==== source/pixelPipe.sv ====
// Needs a memory with one cycle of registered read latency; outputs trail the scan info by 2 cycles
`timescale 1ns/1ps
`default_nettype none

`include "video_cfg.svh"

module pixelPipe (
	input  wire Clock,
	input  wire Reset,
	input  videoPkg::scanInfo Scan_i,
	output framePkg::memRequest FetchRequest_o,
	input  framePkg::cellColour ReadData_i,
	output logic Red_o,
	output logic Green_o,
	output logic Blue_o,
	output logic HSync_o,
	output logic VSync_o
);

	logic fetchNow;
	logic fetched;
	logic active1;
	logic hSync1;
	logic vSync1;
	framePkg::cellColour colourReg;
	framePkg::cellColour colourNow;

	// Read on the first pixel of each cell
	assign fetchNow = Scan_i.active && (Scan_i.column[`CELL_SHIFT-1:0] == '0);

	always_comb begin
		FetchRequest_o.valid = fetchNow;
		FetchRequest_o.write = 1'b0;
		FetchRequest_o.address.row = 6'(Scan_i.row >> `CELL_SHIFT);
		FetchRequest_o.address.column = 7'(Scan_i.column >> `CELL_SHIFT);
		FetchRequest_o.data = '0;
	end

	// Stage one, waiting for the memory
	always_ff @(posedge Clock, negedge Reset) begin
		if (!Reset) begin
			fetched <= 1'b0;
			active1 <= 1'b0;
			hSync1 <= 1'b1;
			vSync1 <= 1'b1;
		end else begin
			fetched <= fetchNow;
			active1 <= Scan_i.active;
			hSync1 <= Scan_i.hSync;
			vSync1 <= Scan_i.vSync;
		end
	end

	// Fresh data on the first pixel, held colour on the other seven
	assign colourNow = fetched ? ReadData_i : colourReg;

	always_ff @(posedge Clock) begin
		if (fetched)
			colourReg <= ReadData_i;
	end

	// Stage two, the port registers
	always_ff @(posedge Clock, negedge Reset) begin
		if (!Reset) begin
			Red_o <= 1'b0;
			Green_o <= 1'b0;
			Blue_o <= 1'b0;
			HSync_o <= 1'b1;
			VSync_o <= 1'b1;
		end else begin
			Red_o <= active1 & colourNow.red;
			Green_o <= active1 & colourNow.green;
			Blue_o <= active1 & colourNow.blue;
			HSync_o <= hSync1;
			VSync_o <= vSync1;
		end
	end

endmodule

`default_nettype wire

// ==== source/scanTiming.sv ====
// Runs free from reset release; the first registered output after release is column 0, row 0
`timescale 1ns/1ps
`default_nettype none

`include "video_cfg.svh"

module scanTiming (
	input  wire Clock,
	input  wire Reset,
	output videoPkg::scanInfo Scan_o
);

	// Last count of each phase, where the state moves on
	localparam logic [9:0] HEndActive = 10'(`H_ACTIVE - 1);
	localparam logic [9:0] HEndFront = 10'(`H_ACTIVE + `H_FRONT - 1);
	localparam logic [9:0] HEndSync = 10'(`H_ACTIVE + `H_FRONT + `H_SYNC - 1);
	localparam logic [9:0] HEndBack = 10'(`H_TOTAL - 1);
	localparam logic [9:0] VEndActive = 10'(`V_ACTIVE - 1);
	localparam logic [9:0] VEndFront = 10'(`V_ACTIVE + `V_FRONT - 1);
	localparam logic [9:0] VEndSync = 10'(`V_ACTIVE + `V_FRONT + `V_SYNC - 1);
	localparam logic [9:0] VEndBack = 10'(`V_TOTAL - 1);

	logic [9:0] hCount;
	logic [9:0] vCount;
	videoPkg::scanState hState;
	videoPkg::scanState vState;
	logic lineEnd;

	assign lineEnd = (hCount == HEndBack);

	// Column wraps at the end of a line, row advances on that wrap
	always_ff @(posedge Clock, negedge Reset) begin
		if (!Reset) begin
			hCount <= '0;
			vCount <= '0;
		end else if (lineEnd) begin
			hCount <= '0;
			if (vCount == VEndBack)
				vCount <= '0;
			else
				vCount <= vCount + 10'd1;
		end else begin
			hCount <= hCount + 10'd1;
		end
	end

	// Horizontal phases
	always_ff @(posedge Clock, negedge Reset) begin
		if (!Reset) begin
			hState <= videoPkg::ScanActive;
		end else begin
			case (hState)
				videoPkg::ScanActive: if (hCount == HEndActive) hState <= videoPkg::ScanFront;
				videoPkg::ScanFront:  if (hCount == HEndFront) hState <= videoPkg::ScanSync;
				videoPkg::ScanSync:   if (hCount == HEndSync) hState <= videoPkg::ScanBack;
				videoPkg::ScanBack:   if (hCount == HEndBack) hState <= videoPkg::ScanActive;
				default:              hState <= videoPkg::ScanActive;
			endcase
		end
	end

	// Vertical phases, only moving on the last column of a line
	always_ff @(posedge Clock, negedge Reset) begin
		if (!Reset) begin
			vState <= videoPkg::ScanActive;
		end else if (lineEnd) begin
			case (vState)
				videoPkg::ScanActive: if (vCount == VEndActive) vState <= videoPkg::ScanFront;
				videoPkg::ScanFront:  if (vCount == VEndFront) vState <= videoPkg::ScanSync;
				videoPkg::ScanSync:   if (vCount == VEndSync) vState <= videoPkg::ScanBack;
				videoPkg::ScanBack:   if (vCount == VEndBack) vState <= videoPkg::ScanActive;
				default:              vState <= videoPkg::ScanActive;
			endcase
		end
	end

	// Registered view of the beam, syncs idle high during reset
	always_ff @(posedge Clock, negedge Reset) begin
		if (!Reset) begin
			Scan_o <= '{column: '0, row: '0, active: 1'b0, hSync: 1'b1, vSync: 1'b1};
		end else begin
			Scan_o.column <= hCount;
			Scan_o.row <= vCount;
			Scan_o.active <= (hState == videoPkg::ScanActive) && (vState == videoPkg::ScanActive);
			Scan_o.hSync <= (hState != videoPkg::ScanSync);
			Scan_o.vSync <= (vState != videoPkg::ScanSync);
		end
	end

endmodule

`default_nettype wire

// ==== source/framePkg.sv ====
// Memory-side types; colour is 3 bits and the cell address uses a row stride of 128
`default_nettype none

package framePkg;

	// Row in the high bits, column in the low bits
	typedef struct packed {
		logic [5:0] row;
		logic [6:0] column;
	} cellAddr;

	// One bit per gun, red in bit 0
	typedef struct packed {
		logic blue;
		logic green;
		logic red;
	} cellColour;

	// One access to the framebuffer port
	typedef struct packed {
		logic valid;
		logic write;
		cellAddr address;
		cellColour data;
	} memRequest;

	typedef enum logic {
		OpPlot,
		OpFill
	} drawOp;

	// Command from the host; column and row are ignored by a fill
	typedef struct packed {
		drawOp op;
		logic [6:0] column;
		logic [5:0] row;
		cellColour colour;
	} drawCommand;

endpackage

`default_nettype wire

// ==== source/videoPkg.sv ====
// Scan-side types; counter fields are 10 bits, enough for totals up to 1023
`default_nettype none

package videoPkg;

	// Phase of one scan axis, in the order it is traversed
	typedef enum logic [1:0] {
		ScanActive,
		ScanFront,
		ScanSync,
		ScanBack
	} scanState;

	// Beam position and sync levels for one pixel clock
	typedef struct packed {
		logic [9:0] column;
		logic [9:0] row;
		// Both axes in their active phase
		logic active;
		// Active-low sync levels
		logic hSync;
		logic vSync;
	} scanInfo;

endpackage

`default_nettype wire

// ==== include/video_cfg.svh ====
// Fixed 640x480 at 60 Hz from a 25.175 MHz pixel clock; other modes need edits to these values
`ifndef VIDEO_CFG_SVH
`define VIDEO_CFG_SVH

// Horizontal timing in pixel clocks
`define H_ACTIVE 640
`define H_FRONT 16
`define H_SYNC 96
`define H_BACK 48

// Vertical timing in lines
`define V_ACTIVE 480
`define V_FRONT 10
`define V_SYNC 2
`define V_BACK 33

// Full line and frame lengths
`define H_TOTAL (`H_ACTIVE + `H_FRONT + `H_SYNC + `H_BACK)
`define V_TOTAL (`V_ACTIVE + `V_FRONT + `V_SYNC + `V_BACK)

// Cells are 8x8 pixels
`define CELL_SHIFT 3

// Visible cell grid
`define GRID_COLS 80
`define GRID_ROWS 60

// Row stride of 128 cells, 64 rows
`define ADDR_BITS 13

`endif
